// File: verilog/font8x8.mem
// one glyph per line, glyph code 0 first: 64 bits, top row in the high byte,
// leftmost pixel in the msb of each row byte.
0000000000000000
183C66667E666600
7C66667C66667C00
3C66606060663C00
786C6666666C7800
7E60607860607E00
7E60607860606000
3C66606E66663C00
6666667E66666600
3C18181818183C00
1E0C0C0C0C6C3800
666C7870786C6600
6060606060607E00
63777F6B63636300
66767E7E6E666600
3C66666666663C00
7C66667C60606000
3C666666663C0E00
7C66667C786C6600
3C66603C06663C00
7E18181818181800
6666666666663C00
66666666663C1800
6363636B7F776300
66663C183C666600
6666663C18181800
7E060C1830607E00
3C666E7666663C00
1818381818187E00
FF818181818181FF
AA55AA55AA55AA55
FFFFFFFFFFFFFFFF

// File: filelist.f
verilog/text_display_pkg.sv
verilog/font_rom.sv
verilog/text_line_buf.sv
verilog/text_ram.sv
verilog/scan_timing.sv
verilog/text_driver.sv
verilog/text_display_top.sv
tb/text_display_chk.sv
tb/tb_text_display.sv

// File: Bender.yml
package:
  name: text_display

sources:
  - files:
      - verilog/text_display_pkg.sv
      - verilog/font_rom.sv
      - verilog/text_line_buf.sv
      - verilog/text_ram.sv
      - verilog/scan_timing.sv
      - verilog/text_driver.sv
      - verilog/text_display_top.sv

  - target: test
    files:
      - tb/text_display_chk.sv
      - tb/tb_text_display.sv

// File: tb/tb_text_display.sv
`timescale 1ns/100ps

module tb_text_display;

  import text_display_pkg::*;

  localparam int          ACK_TIMEOUT   = 400;
  localparam int          FRAME_TIMEOUT = H_TOTAL * V_TOTAL + 64;
  localparam logic [31:0] SEED          = 32'ha686_6887;
  localparam int          NUM_ENTRIES   = 8;
  localparam int          NUM_WRITES    = 10;

  typedef struct packed {
    logic [7:0]          wr_first;
    logic [7:0]          wr_count;
    logic                fill;    // random fill of the whole text memory.
    logic                live;    // writes start during active display.
    logic [COL_BITS-1:0] ccol;
    logic [ROW_BITS-1:0] crow;
    logic [1:0]          cmode;
    logic [3:0]          frames;
  } entry_t;

  typedef struct packed {
    logic [TEXT_AWIDTH-1:0] adr;
    text_word_u             word;
  } host_wr_t;

  logic                   clk_i = 1'b0;
  logic                   rst_i;
  logic                   host_req_i;
  logic [TEXT_AWIDTH-1:0] host_addr_i;
  text_word_u             host_data_i;
  logic                   host_ack_o;
  logic [COL_BITS-1:0]    cursor_col_i;
  logic [ROW_BITS-1:0]    cursor_row_i;
  logic [1:0]             cursor_mode_i;
  logic [7:0]             red_o;
  logic [7:0]             green_o;
  logic [7:0]             blue_o;
  logic                   de_o;
  logic                   hsync_o;
  logic                   vsync_o;
  logic [GLYPH_BITS-1:0]  font [GLYPH_COUNT];
  text_word_u             shadow [TEXT_WORDS];
  entry_t                 entries [NUM_ENTRIES];
  host_wr_t               writes [NUM_WRITES];
  int                     vsync_count = 0;
  logic                   vsync_last = 1'b0;

  always #2 clk_i = ~clk_i;

  text_display_top i_dut (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .host_req_i    (host_req_i),
    .host_addr_i   (host_addr_i),
    .host_data_i   (host_data_i),
    .host_ack_o    (host_ack_o),
    .cursor_col_i  (cursor_col_i),
    .cursor_row_i  (cursor_row_i),
    .cursor_mode_i (cursor_mode_i),
    .red_o         (red_o),
    .green_o       (green_o),
    .blue_o        (blue_o),
    .de_o          (de_o),
    .hsync_o       (hsync_o),
    .vsync_o       (vsync_o)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] got);
    if (got !== expected)
    begin
      stop_run($sformatf("Error at %0t: %s expected %h got %h", $time, name, expected, got));
    end
  endtask

  // frame k is shown after k vsync edges, and frame 0 already counts as a frame start.
  always @(negedge clk_i)
  begin
    vsync_last <= vsync_o;
    if (vsync_o && !vsync_last)
    begin
      vsync_count <= vsync_count + 1;
    end
    if (i_dut.u_chk.fail_count != 0)
    begin
      stop_run("a protocol or blanking assertion failed");
    end
  end

  function automatic text_word_u random_word();
    text_word_u w;
    w.cells.colour_hi = 8'($urandom);
    w.cells.glyph_hi  = 8'($urandom % GLYPH_COUNT);
    w.cells.colour_lo = 8'($urandom);
    w.cells.glyph_lo  = 8'($urandom % GLYPH_COUNT);
    return w;
  endfunction

  function automatic logic [23:0] expected_rgb(input int x, input int y, input entry_t ent);
    text_word_u            word;
    logic [GLYPH_BITS-1:0] glyph;
    logic [7:0]            colour;
    logic [7:0]            bits;
    logic                  lit;
    logic                  phase;
    int                    col;
    int                    row;
    col  = x / 8;
    row  = y / 8;
    word = shadow[row * WORDS_PER_ROW + col / 2];
    if (col % 2 == 0)
    begin
      colour = word.cells.colour_hi;
      glyph  = font[word.cells.glyph_hi % GLYPH_COUNT];
    end
    else
    begin
      colour = word.cells.colour_lo;
      glyph  = font[word.cells.glyph_lo % GLYPH_COUNT];
    end
    bits  = glyph[GLYPH_BITS - 1 - 8 * (y % 8) -: 8];
    lit   = bits[7 - x % 8];
    phase = ((vsync_count + 1) / BLINK_FRAMES) % 2;
    if ((col == ent.ccol) && (row == ent.crow) &&
        ((ent.cmode == CURSOR_STEADY) || ((ent.cmode == CURSOR_BLINK) && phase)))
    begin
      lit = 1'b1;
    end
    if (!lit)
    begin
      return 24'h0;
    end
    return {colour[7:5], 5'b0, colour[4:2], 5'b0, colour[1:0], 6'b0};
  endfunction

  task automatic host_write(input logic [TEXT_AWIDTH-1:0] adr, input text_word_u word);
    int waited;
    @(posedge clk_i);
    host_req_i  <= 1'b1;
    host_addr_i <= adr;
    host_data_i <= word;
    waited = 0;
    @(negedge clk_i);
    while (!host_ack_o)
    begin
      if (waited == ACK_TIMEOUT)
      begin
        stop_run("host write timed out waiting for host_ack_o to rise");
      end
      waited++;
      @(negedge clk_i);
    end
    shadow[adr] = word;
    @(posedge clk_i);
    host_req_i <= 1'b0;
    waited = 0;
    @(negedge clk_i);
    while (host_ack_o)
    begin
      if (waited == ACK_TIMEOUT)
      begin
        stop_run("host write timed out waiting for host_ack_o to fall");
      end
      waited++;
      @(negedge clk_i);
    end
  endtask

  task automatic wait_frame_start();
    int   waited;
    logic last;
    waited = 0;
    @(negedge clk_i);
    last = vsync_o;
    @(negedge clk_i);
    while (!(vsync_o && !last))
    begin
      if (waited == FRAME_TIMEOUT)
      begin
        stop_run("no rising edge on vsync_o within a frame");
      end
      waited++;
      last = vsync_o;
      @(negedge clk_i);
    end
  endtask

  // returns just after the first active line of a frame, while its fetch runs.
  task automatic wait_line_end();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!de_o)
    begin
      if (waited == FRAME_TIMEOUT)
      begin
        stop_run("de_o never went high");
      end
      waited++;
      @(negedge clk_i);
    end
    waited = 0;
    while (de_o)
    begin
      if (waited == H_TOTAL)
      begin
        stop_run("de_o stayed high past a full line");
      end
      waited++;
      @(negedge clk_i);
    end
  endtask

  // walks the raster from the vsync edge up to the last active pixel of the next frame.
  task automatic check_frame(input entry_t ent);
    int last;
    int x;
    int y;
    last = (V_TOTAL - VSYNC_START + V_ACTIVE - 1) * H_TOTAL + H_ACTIVE - 1;
    for (int k = 1; k <= last; k++)
    begin
      @(negedge clk_i);
      x = k % H_TOTAL;
      y = (VSYNC_START + k / H_TOTAL) % V_TOTAL;
      check_value("de_o", 32'((x < H_ACTIVE) && (y < V_ACTIVE)), 32'(de_o));
      check_value("hsync_o", 32'((x >= HSYNC_START) && (x < HSYNC_END)), 32'(hsync_o));
      check_value("vsync_o", 32'((y >= VSYNC_START) && (y < VSYNC_END)), 32'(vsync_o));
      if ((x < H_ACTIVE) && (y < V_ACTIVE))
      begin
        check_value($sformatf("{red_o,green_o,blue_o} at x=%0d y=%0d", x, y),
                    {8'h0, expected_rgb(x, y, ent)}, {8'h0, red_o, green_o, blue_o});
      end
    end
  endtask

  initial
  begin
    entry_t ent;
    int     seed_ret;
    rst_i         = 1'b1;
    host_req_i    = 1'b0;
    host_addr_i   = '0;
    host_data_i   = '0;
    cursor_col_i  = '0;
    cursor_row_i  = '0;
    cursor_mode_i = CURSOR_OFF;
    seed_ret = $urandom(SEED);
    $readmemh(FONT_FILE, font);
    for (int i = 0; i < TEXT_WORDS; i++)
    begin
      shadow[i] = '0;  // matches the reset sweep.
    end
    writes[0] = '{6'd0,  32'hE001_1C02};
    writes[1] = '{6'd9,  32'h031D_FF1F};
    writes[2] = '{6'd23, 32'hFC13_1F14};
    writes[3] = '{6'd59, 32'h921E_6D1B};
    writes[4] = '{6'd30, 32'hFF1F_E309};
    writes[5] = '{6'd0,  32'h1F18_E019};
    writes[6] = '{6'd45, 32'hFF1F_FF1F};
    writes[7] = '{6'd45, 32'h1C11_030F};  // same word again, last write wins.
    writes[8] = '{6'd19, 32'hE31C_4A07};
    writes[9] = '{6'd50, 32'h2510_B60C};
    // first, count, fill, live, column, row, mode, frames.
    entries[0] = '{8'd0, 8'd0, 1'b1, 1'b0, 5'd0,  3'd0, CURSOR_OFF,    4'd1};
    entries[1] = '{8'd0, 8'd5, 1'b0, 1'b0, 5'd0,  3'd0, CURSOR_OFF,    4'd1};
    entries[2] = '{8'd0, 8'd0, 1'b0, 1'b0, 5'd7,  3'd2, CURSOR_STEADY, 4'd1};
    entries[3] = '{8'd0, 8'd0, 1'b0, 1'b0, 5'd0,  3'd0, CURSOR_STEADY, 4'd1};
    entries[4] = '{8'd0, 8'd0, 1'b0, 1'b0, 5'd7,  3'd2, CURSOR_OFF,    4'd1};
    entries[5] = '{8'd0, 8'd0, 1'b0, 1'b0, 5'd13, 3'd4, CURSOR_BLINK,  4'd4};
    entries[6] = '{8'd5, 8'd5, 1'b0, 1'b1, 5'd19, 3'd5, CURSOR_BLINK,  4'd2};
    entries[7] = '{8'd0, 8'd0, 1'b1, 1'b1, 5'd10, 3'd3, CURSOR_STEADY, 4'd1};
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    for (int e = 0; e < NUM_ENTRIES; e++)
    begin
      ent = entries[e];
      @(posedge clk_i);
      cursor_col_i  <= ent.ccol;
      cursor_row_i  <= ent.crow;
      cursor_mode_i <= ent.cmode;
      if (ent.live)
      begin
        wait_frame_start();
        wait_line_end();
      end
      if (ent.fill)
      begin
        for (int a = 0; a < TEXT_WORDS; a++)
        begin
          host_write(TEXT_AWIDTH'(a), random_word());
        end
      end
      for (int w = 0; w < ent.wr_count; w++)
      begin
        host_write(writes[ent.wr_first + w].adr, writes[ent.wr_first + w].word);
      end
      for (int f = 0; f < ent.frames; f++)
      begin
        wait_frame_start();
        check_frame(ent);
      end
    end
    if (i_dut.u_chk.fail_count == 0)
    begin
      $display("Simulation passed");
      $finish;
    end
    else
    begin
      $display("Simulation failed");
      $fatal(1, "assertion failures at the end of the run");
    end
  end

endmodule

// File: tb/text_display_chk.sv
`timescale 1ns/100ps

module text_display_chk
  (
  input logic       clk_i,
  input logic       rst_i,
  input logic       host_req_i,
  input logic       host_ack_i,
  input logic       de_i,
  input logic [7:0] red_i,
  input logic [7:0] green_i,
  input logic [7:0] blue_i
  );

  int fail_count = 0;

  // ack only answers a pending request.
  ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(host_ack_i) |-> host_req_i)
  else
  begin
    fail_count++;
    $error("host_ack_o rose while host_req_i was low");
  end

  ack_after_req_low: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(host_ack_i) |-> !$past(host_req_i))
  else
  begin
    fail_count++;
    $error("host_ack_o fell before host_req_i was dropped");
  end

  // blanking is black.
  rgb_dark_in_blank: assert property (@(posedge clk_i) disable iff (rst_i)
    !de_i |-> ((red_i == 8'd0) && (green_i == 8'd0) && (blue_i == 8'd0)))
  else
  begin
    fail_count++;
    $error("rgb not zero outside the active area");
  end

endmodule

bind text_display_top text_display_chk u_chk (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .host_req_i (host_req_i),
  .host_ack_i (host_ack_o),
  .de_i       (de_o),
  .red_i      (red_o),
  .green_i    (green_o),
  .blue_i     (blue_o)
);

// File: verilog/text_display_top.sv
`timescale 1ns/100ps

module text_display_top
  (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  logic                                     host_req_i,
  input  logic [text_display_pkg::TEXT_AWIDTH-1:0] host_addr_i,
  input  text_display_pkg::text_word_u             host_data_i,
  output logic                                     host_ack_o,
  input  logic [text_display_pkg::COL_BITS-1:0]    cursor_col_i,
  input  logic [text_display_pkg::ROW_BITS-1:0]    cursor_row_i,
  input  logic [1:0]                               cursor_mode_i,
  output logic [7:0]                               red_o,
  output logic [7:0]                               green_o,
  output logic [7:0]                               blue_o,
  output logic                                     de_o,
  output logic                                     hsync_o,
  output logic                                     vsync_o
  );

  import text_display_pkg::*;

  logic [X_BITS-1:0]      t_x;
  logic [Y_BITS-1:0]      t_y;
  logic                   t_de;
  logic                   t_hsync;
  logic                   t_vsync;
  logic                   t_frame_start;
  logic                   fetch_cyc;
  logic                   fetch_ack;
  logic [TEXT_AWIDTH-1:0] fetch_adr;
  text_word_u             fetch_dat;
  logic [PIX_LATENCY-1:0] de_pipe;
  logic [PIX_LATENCY-1:0] hsync_pipe;
  logic [PIX_LATENCY-1:0] vsync_pipe;

  scan_timing u_timing (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .x_o           (t_x),
    .y_o           (t_y),
    .de_o          (t_de),
    .hsync_o       (t_hsync),
    .vsync_o       (t_vsync),
    .frame_start_o (t_frame_start)
  );

  text_ram u_text_ram (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .host_req_i  (host_req_i),
    .host_addr_i (host_addr_i),
    .host_data_i (host_data_i),
    .host_ack_o  (host_ack_o),
    .fetch_cyc_i (fetch_cyc),
    .fetch_adr_i (fetch_adr),
    .fetch_dat_o (fetch_dat),
    .fetch_ack_o (fetch_ack)
  );

  text_driver u_driver (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .x_i           (t_x),
    .y_i           (t_y),
    .de_i          (t_de),
    .frame_start_i (t_frame_start),
    .cursor_col_i  (cursor_col_i),
    .cursor_row_i  (cursor_row_i),
    .cursor_mode_i (cursor_mode_i),
    .fetch_cyc_o   (fetch_cyc),
    .fetch_adr_o   (fetch_adr),
    .fetch_dat_i   (fetch_dat),
    .fetch_ack_i   (fetch_ack),
    .red_o         (red_o),
    .green_o       (green_o),
    .blue_o        (blue_o)
  );

  // strobes follow the pixel pipeline.
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      de_pipe    <= '0;
      hsync_pipe <= '0;
      vsync_pipe <= '0;
    end
    else
    begin
      de_pipe    <= {de_pipe[PIX_LATENCY-2:0], t_de};
      hsync_pipe <= {hsync_pipe[PIX_LATENCY-2:0], t_hsync};
      vsync_pipe <= {vsync_pipe[PIX_LATENCY-2:0], t_vsync};
    end
  end

  assign de_o    = de_pipe[PIX_LATENCY-1];
  assign hsync_o = hsync_pipe[PIX_LATENCY-1];
  assign vsync_o = vsync_pipe[PIX_LATENCY-1];

endmodule

// File: verilog/text_driver.sv
`timescale 1ns/100ps

module text_driver
  (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  logic [text_display_pkg::X_BITS-1:0]      x_i,
  input  logic [text_display_pkg::Y_BITS-1:0]      y_i,
  input  logic                                     de_i,
  input  logic                                     frame_start_i,
  input  logic [text_display_pkg::COL_BITS-1:0]    cursor_col_i,
  input  logic [text_display_pkg::ROW_BITS-1:0]    cursor_row_i,
  input  logic [1:0]                               cursor_mode_i,
  output logic                                     fetch_cyc_o,
  output logic [text_display_pkg::TEXT_AWIDTH-1:0] fetch_adr_o,
  input  text_display_pkg::text_word_u             fetch_dat_i,
  input  logic                                     fetch_ack_i,
  output logic [7:0]                               red_o,
  output logic [7:0]                               green_o,
  output logic [7:0]                               blue_o
  );

  import text_display_pkg::*;

  logic [1:0]             state;
  logic [LBUF_AWIDTH-1:0] word_idx;
  logic [TEXT_AWIDTH-1:0] row_base;
  logic [2:0]             glyph_line;
  text_word_u             cell_word;
  logic [Y_BITS-1:0]      next_y;
  logic                   start_fetch;
  logic [GLYPH_BITS-1:0]  glyph_hi;
  logic [GLYPH_BITS-1:0]  glyph_lo;
  logic [7:0]             row_hi;
  logic [7:0]             row_lo;
  logic [LBUF_BITS-1:0]   lbuf_wr_dat;
  logic [LBUF_BITS-1:0]   lbuf_rd_dat;
  logic [1:0]             blink_cnt;
  logic                   blink_phase;
  logic                   cursor_on;
  logic                   cursor_hit;
  logic                   de_d;
  logic                   cursor_d;
  logic [3:0]             xsub_d;
  logic                   pix_on;
  logic [7:0]             pix_colour;

  // the last raster line prefetches line 0.
  assign next_y = (y_i == Y_BITS'(V_TOTAL - 1)) ? '0 : y_i + 1'b1;
  assign start_fetch = (state == ST_IDLE) && (x_i == X_BITS'(H_ACTIVE)) &&
                       (next_y < Y_BITS'(V_ACTIVE));

  assign fetch_cyc_o = (state == ST_BUS);
  assign fetch_adr_o = row_base + TEXT_AWIDTH'(word_idx);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state      <= ST_IDLE;
      word_idx   <= '0;
      row_base   <= '0;
      glyph_line <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (start_fetch)
          begin
            row_base   <= TEXT_AWIDTH'(next_y[Y_BITS-1:3] * WORDS_PER_ROW);
            glyph_line <= next_y[2:0];
            word_idx   <= '0;
            state      <= ST_BUS;
          end
        end
        ST_BUS:   if (fetch_ack_i) state <= ST_FONT;
        ST_FONT:  state <= ST_STORE;  // glyph rom read.
        ST_STORE:
        begin
          if (word_idx == LBUF_AWIDTH'(WORDS_PER_ROW - 1))
          begin
            state <= ST_IDLE;
          end
          else
          begin
            word_idx <= word_idx + 1'b1;
            state    <= ST_BUS;
          end
        end
        default:  state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if ((state == ST_BUS) && fetch_ack_i)
    begin
      cell_word <= fetch_dat_i;
    end
  end

  font_rom u_font_rom (
    .clk_i   (clk_i),
    .adr_a_i (cell_word.cells.glyph_hi[FONT_AWIDTH-1:0]),
    .dat_a_o (glyph_hi),
    .adr_b_i (cell_word.cells.glyph_lo[FONT_AWIDTH-1:0]),
    .dat_b_o (glyph_lo)
  );

  assign row_hi = glyph_hi[GLYPH_BITS-1 - 8*glyph_line -: 8];
  assign row_lo = glyph_lo[GLYPH_BITS-1 - 8*glyph_line -: 8];
  assign lbuf_wr_dat = {cell_word.cells.colour_hi, cell_word.cells.colour_lo, row_hi, row_lo};

  text_line_buf u_line_buf (
    .clk_i    (clk_i),
    .we_i     (state == ST_STORE),
    .wr_adr_i (word_idx),
    .wr_dat_i (lbuf_wr_dat),
    .rd_adr_i (x_i[LBUF_AWIDTH+3:4]),
    .rd_dat_o (lbuf_rd_dat)
  );

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      blink_cnt   <= '0;
      blink_phase <= 1'b0;
    end
    else if (frame_start_i)
    begin
      if (blink_cnt == 2'(BLINK_FRAMES - 1))
      begin
        blink_cnt   <= '0;
        blink_phase <= ~blink_phase;
      end
      else
      begin
        blink_cnt <= blink_cnt + 1'b1;
      end
    end
  end

  always_comb
  begin
    case (cursor_mode_i)
      CURSOR_OFF:    cursor_on = 1'b0;
      CURSOR_BLINK:  cursor_on = blink_phase;
      CURSOR_STEADY: cursor_on = 1'b1;
      default:       cursor_on = 1'b0;
    endcase
  end

  assign cursor_hit = cursor_on && (x_i[COL_BITS+2:3] == cursor_col_i) &&
                      (y_i[ROW_BITS+2:3] == cursor_row_i);

  // first stage lines up with the registered line buffer read.
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      de_d     <= 1'b0;
      cursor_d <= 1'b0;
      xsub_d   <= '0;
    end
    else
    begin
      de_d     <= de_i;
      cursor_d <= cursor_hit;
      xsub_d   <= x_i[3:0];
    end
  end

  assign pix_on     = lbuf_rd_dat[15 - xsub_d];  // odd cell in the low row byte.
  assign pix_colour = xsub_d[3] ? lbuf_rd_dat[23:16] : lbuf_rd_dat[31:24];

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      red_o   <= '0;
      green_o <= '0;
      blue_o  <= '0;
    end
    else if (de_d && (pix_on || cursor_d))
    begin
      red_o   <= {pix_colour[7:5], 5'b0};
      green_o <= {pix_colour[4:2], 5'b0};
      blue_o  <= {pix_colour[1:0], 6'b0};
    end
    else
    begin
      red_o   <= '0;
      green_o <= '0;
      blue_o  <= '0;
    end
  end

endmodule

// File: verilog/scan_timing.sv
`timescale 1ns/100ps

module scan_timing
  (
  input  logic                                clk_i,
  input  logic                                rst_i,
  output logic [text_display_pkg::X_BITS-1:0] x_o,
  output logic [text_display_pkg::Y_BITS-1:0] y_o,
  output logic                                de_o,
  output logic                                hsync_o,
  output logic                                vsync_o,
  output logic                                frame_start_o
  );

  import text_display_pkg::*;

  logic line_end;
  logic frame_end;

  assign line_end  = (x_o == X_BITS'(H_TOTAL - 1));
  assign frame_end = (y_o == Y_BITS'(V_TOTAL - 1));

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      x_o <= '0;
      y_o <= '0;
    end
    else if (line_end)
    begin
      x_o <= '0;
      if (frame_end)
      begin
        y_o <= '0;
      end
      else
      begin
        y_o <= y_o + 1'b1;
      end
    end
    else
    begin
      x_o <= x_o + 1'b1;
    end
  end

  assign de_o    = (x_o < X_BITS'(H_ACTIVE)) && (y_o < Y_BITS'(V_ACTIVE));
  // syncs are active high.
  assign hsync_o = (x_o >= X_BITS'(HSYNC_START)) && (x_o < X_BITS'(HSYNC_END));
  assign vsync_o = (y_o >= Y_BITS'(VSYNC_START)) && (y_o < Y_BITS'(VSYNC_END));
  assign frame_start_o = (x_o == '0) && (y_o == '0);

endmodule

// File: verilog/text_ram.sv
`timescale 1ns/100ps

module text_ram
  (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  logic                                     host_req_i,
  input  logic [text_display_pkg::TEXT_AWIDTH-1:0] host_addr_i,
  input  text_display_pkg::text_word_u             host_data_i,
  output logic                                     host_ack_o,
  input  logic                                     fetch_cyc_i,
  input  logic [text_display_pkg::TEXT_AWIDTH-1:0] fetch_adr_i,
  output text_display_pkg::text_word_u             fetch_dat_o,
  output logic                                     fetch_ack_o
  );

  import text_display_pkg::*;

  text_word_u             mem [TEXT_WORDS];
  logic [1:0]             host_phase;
  logic                   clr_busy;
  logic [TEXT_AWIDTH-1:0] clr_adr;
  logic                   fetch_req;
  logic                   fetch_gnt;
  logic                   host_gnt;

  assign fetch_req = fetch_cyc_i && !fetch_ack_o;  // cyc still high in the ack cycle.
  assign fetch_gnt = fetch_req && !clr_busy && (host_phase != HP_WRITE);
  assign host_gnt  = host_req_i && (host_phase == HP_IDLE) && !clr_busy && !fetch_req;
  assign host_ack_o = (host_phase == HP_ACK);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      host_phase  <= HP_IDLE;
      clr_busy    <= 1'b1;
      clr_adr     <= '0;
      fetch_ack_o <= 1'b0;
    end
    else
    begin
      fetch_ack_o <= fetch_gnt;
      if (clr_busy)
      begin
        clr_busy <= (clr_adr != TEXT_AWIDTH'(TEXT_WORDS - 1));
        clr_adr  <= clr_adr + 1'b1;
      end
      case (host_phase)
        HP_IDLE:  if (host_gnt) host_phase <= HP_WRITE;
        HP_WRITE: host_phase <= HP_ACK;
        HP_ACK:   if (!host_req_i) host_phase <= HP_IDLE;
        default:  host_phase <= HP_IDLE;
      endcase
    end
  end

  // single port: sweep, then host write or fetch read.
  always_ff @(posedge clk_i)
  begin
    if (clr_busy)
    begin
      mem[clr_adr] <= '0;
    end
    else if ((host_phase == HP_WRITE) && (host_addr_i < TEXT_AWIDTH'(TEXT_WORDS)))
    begin
      mem[host_addr_i] <= host_data_i;
    end
    if (fetch_gnt)
    begin
      fetch_dat_o <= mem[fetch_adr_i];
    end
  end

endmodule

// File: verilog/text_line_buf.sv
`timescale 1ns/100ps

module text_line_buf
  (
  input  logic                                     clk_i,
  input  logic                                     we_i,
  input  logic [text_display_pkg::LBUF_AWIDTH-1:0] wr_adr_i,
  input  logic [text_display_pkg::LBUF_BITS-1:0]   wr_dat_i,
  input  logic [text_display_pkg::LBUF_AWIDTH-1:0] rd_adr_i,
  output logic [text_display_pkg::LBUF_BITS-1:0]   rd_dat_o
  );

  import text_display_pkg::*;

  logic [LBUF_BITS-1:0] mem [WORDS_PER_ROW];

  // written in hblank, read during the active part of the next line.
  always_ff @(posedge clk_i)
  begin
    if (we_i)
    begin
      mem[wr_adr_i] <= wr_dat_i;
    end
    rd_dat_o <= mem[rd_adr_i];
  end

endmodule

// File: verilog/font_rom.sv
`timescale 1ns/100ps

module font_rom
  (
  input  logic                                     clk_i,
  input  logic [text_display_pkg::FONT_AWIDTH-1:0] adr_a_i,
  output logic [text_display_pkg::GLYPH_BITS-1:0]  dat_a_o,
  input  logic [text_display_pkg::FONT_AWIDTH-1:0] adr_b_i,
  output logic [text_display_pkg::GLYPH_BITS-1:0]  dat_b_o
  );

  import text_display_pkg::*;

  logic [GLYPH_BITS-1:0] rom [GLYPH_COUNT];

  initial
  begin
    $readmemh(FONT_FILE, rom);
  end

  // both cells of a word are looked up in the same cycle.
  always_ff @(posedge clk_i)
  begin
    dat_a_o <= rom[adr_a_i];
    dat_b_o <= rom[adr_b_i];
  end

endmodule

// File: verilog/text_display_pkg.sv
package text_display_pkg;

  // raster, reduced for short simulation runs.
  localparam int H_ACTIVE    = 160;
  localparam int H_TOTAL     = 256;
  localparam int HSYNC_START = 176;
  localparam int HSYNC_END   = 200;
  localparam int V_ACTIVE    = 48;
  localparam int V_TOTAL     = 52;
  localparam int VSYNC_START = 49;
  localparam int VSYNC_END   = 50;
  localparam int X_BITS      = 9;
  localparam int Y_BITS      = 6;

  localparam int TEXT_COLS     = 20;
  localparam int TEXT_ROWS     = 6;
  localparam int WORDS_PER_ROW = 10;  // two cells per word.
  localparam int TEXT_AWIDTH   = 6;
  localparam int TEXT_WORDS    = TEXT_ROWS * WORDS_PER_ROW;
  localparam int COL_BITS      = $clog2(TEXT_COLS);
  localparam int ROW_BITS      = $clog2(TEXT_ROWS);

  // glyph rows top first, leftmost pixel in the msb of each row.
  localparam int    GLYPH_COUNT = 32;
  localparam int    FONT_AWIDTH = 5;
  localparam int    GLYPH_BITS  = 64;
  localparam string FONT_FILE   = "verilog/font8x8.mem";

  localparam int LBUF_AWIDTH = $clog2(WORDS_PER_ROW);
  localparam int LBUF_BITS   = 32;   // two colours, two glyph rows.

  localparam int         BLINK_FRAMES  = 2;
  localparam logic [1:0] CURSOR_OFF    = 2'd0;
  localparam logic [1:0] CURSOR_BLINK  = 2'd1;
  localparam logic [1:0] CURSOR_STEADY = 2'd2;

  localparam int PIX_LATENCY = 2;

  // fetch FSM states.
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_BUS   = 2'd1;
  localparam logic [1:0] ST_FONT  = 2'd2;
  localparam logic [1:0] ST_STORE = 2'd3;

  // host port phases.
  localparam logic [1:0] HP_IDLE  = 2'd0;
  localparam logic [1:0] HP_WRITE = 2'd1;
  localparam logic [1:0] HP_ACK   = 2'd2;

  // high cell is the even column.
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [7:0] colour_hi;
      logic [7:0] glyph_hi;
      logic [7:0] colour_lo;
      logic [7:0] glyph_lo;
    } cells;
  } text_word_u;

endpackage
